/* runSim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module executeUnitTb -Mdir obj_dir -o executeUnitSim \
  -f verilog.f || { echo "verilator build failed"; exit 1; }
./obj_dir/executeUnitSim > sim.log 2>&1
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
  input  mipsExecPkg::aluCtlT aluCtl,
  output mipsExecPkg::aluOutT aluOut
);
  import mipsExecPkg::*;

  logic [31:0] opA;
  logic [31:0] opB;
  logic [4:0]  shAmt;
  logic        lessThan;
  logic [63:0] product;
  logic [31:0] quot;
  logic [31:0] rem;

  assign opA   = aluCtl.operandA;
  assign opB   = aluCtl.operandB;
  assign shAmt = opB[4:0]; // upper bits of the shift amount are ignored

  assign lessThan = aluCtl.unsign ? (opA < opB) : ($signed(opA) < $signed(opB));

  // operands sign or zero extend to the 64 bit product
  always_comb begin
    if (aluCtl.unsign) begin
      product = {32'b0, opA} * {32'b0, opB};
    end else begin
      product = 64'($signed(opA)) * 64'($signed(opB));
    end
  end

  // quotient goes to lo, remainder to hi
  always_comb begin
    if (opB == '0) begin
      quot = wordOnes;
      rem  = opA;
    end else if (!aluCtl.unsign && opA == wordMinNeg && opB == wordOnes) begin
      quot = opA; // signed overflow case
      rem  = '0;
    end else if (aluCtl.unsign) begin
      quot = opA / opB;
      rem  = opA % opB;
    end else begin
      quot = $signed(opA) / $signed(opB);
      rem  = $signed(opA) % $signed(opB);
    end
  end

  always_comb begin
    aluOut = '0;
    case (aluCtl.op)
      aluAdd: begin
        aluOut.result = opA + opB; // wraps, same for signed and unsigned
      end
      aluSub: begin
        aluOut.result = opA - opB;
        aluOut.eq     = (opA == opB);
        aluOut.lt     = lessThan;
      end
      aluAnd: begin
        aluOut.result = opA & opB;
      end
      aluOr: begin
        aluOut.result = opA | opB;
      end
      aluXor: begin
        aluOut.result = opA ^ opB;
      end
      aluSlt: begin
        aluOut.result = {31'b0, lessThan};
      end
      aluMult: begin
        aluOut.hi = product[63:32];
        aluOut.lo = product[31:0];
      end
      aluDiv: begin
        aluOut.hi = rem;
        aluOut.lo = quot;
      end
      aluSll: begin
        aluOut.result = opA << shAmt;
      end
      aluSrl: begin
        aluOut.result = opA >> shAmt;
      end
      aluSra: begin
        aluOut.result = $signed(opA) >>> shAmt; // sign fill
      end
      aluLui: begin
        aluOut.result = opB; // imm already in upper half
      end
      aluPassA: begin
        aluOut.result = opA;
      end
      default: ;
    endcase
  end

endmodule

/* source/aluControl.sv */
`timescale 1ns/1ps

module aluControl (
  input  mipsExecPkg::execReqT execReq,
  output mipsExecPkg::aluCtlT  aluCtl
);
  import mipsExecPkg::*;

  logic [31:0] immSext;
  logic [31:0] immZext;
  logic [31:0] shamtImm;
  logic [31:0] shamtVar;

  assign immSext  = {{16{execReq.imm[15]}}, execReq.imm};
  assign immZext  = {16'b0, execReq.imm};
  assign shamtImm = {27'b0, execReq.shamt};
  assign shamtVar = {27'b0, execReq.rsVal[4:0]}; // only 5 bits count

  always_comb begin
    aluCtl = '0; // add of zeros, no side effects
    aluCtl.op = aluAdd;
    case (execReq.opcode)
      opSpecial: begin
        aluCtl.operandA = execReq.rsVal;
        aluCtl.operandB = execReq.rtVal;
        case (functE'(execReq.funct))
          fnSll, fnSrl, fnSra: begin
            aluCtl.operandA = execReq.rtVal;
            aluCtl.operandB = shamtImm;
            aluCtl.op = (functE'(execReq.funct) == fnSll) ? aluSll :
                        (functE'(execReq.funct) == fnSrl) ? aluSrl : aluSra;
          end
          fnSllv, fnSrlv, fnSrav: begin
            aluCtl.operandA = execReq.rtVal;
            aluCtl.operandB = shamtVar;
            aluCtl.op = (functE'(execReq.funct) == fnSllv) ? aluSll :
                        (functE'(execReq.funct) == fnSrlv) ? aluSrl : aluSra;
          end
          fnAdd:   aluCtl.op = aluAdd; // no overflow trap
          fnAddu: begin
            aluCtl.op = aluAdd;
            aluCtl.unsign = 1'b1;
          end
          fnSub:   aluCtl.op = aluSub;
          fnSubu: begin
            aluCtl.op = aluSub;
            aluCtl.unsign = 1'b1;
          end
          fnAnd:   aluCtl.op = aluAnd;
          fnOr:    aluCtl.op = aluOr;
          fnXor:   aluCtl.op = aluXor;
          fnSlt:   aluCtl.op = aluSlt;
          fnSltu: begin
            aluCtl.op = aluSlt;
            aluCtl.unsign = 1'b1;
          end
          fnMult, fnMultu: begin
            aluCtl.op = aluMult;
            aluCtl.unsign = (functE'(execReq.funct) == fnMultu);
            aluCtl.hiLoWrite = 1'b1;
          end
          fnDiv, fnDivu: begin
            aluCtl.op = aluDiv;
            aluCtl.unsign = (functE'(execReq.funct) == fnDivu);
            aluCtl.hiLoWrite = 1'b1;
          end
          fnMfhi:  aluCtl.readHi = 1'b1;
          fnMflo:  aluCtl.readLo = 1'b1;
          fnMthi: begin
            aluCtl.op = aluPassA;
            aluCtl.hiWrite = 1'b1;
          end
          fnMtlo: begin
            aluCtl.op = aluPassA;
            aluCtl.loWrite = 1'b1;
          end
          default: begin
            aluCtl.operandA = '0; // unknown funct
            aluCtl.operandB = '0;
          end
        endcase
      end
      opAddiu: begin
        aluCtl.operandA = execReq.rsVal;
        aluCtl.operandB = immSext;
        aluCtl.unsign = 1'b1;
      end
      opSlti, opSltiu: begin
        aluCtl.op = aluSlt;
        aluCtl.operandA = execReq.rsVal;
        aluCtl.operandB = immSext; // sltiu still sign extends
        aluCtl.unsign = (execReq.opcode == opSltiu);
      end
      opAndi, opOri, opXori: begin
        aluCtl.operandA = execReq.rsVal;
        aluCtl.operandB = immZext;
        aluCtl.op = (execReq.opcode == opAndi) ? aluAnd :
                    (execReq.opcode == opOri) ? aluOr : aluXor;
      end
      opLui: begin
        aluCtl.op = aluLui;
        aluCtl.operandB = {execReq.imm, 16'b0};
      end
      opBeq, opBne: begin
        aluCtl.op = aluSub;
        aluCtl.operandA = execReq.rsVal;
        aluCtl.operandB = execReq.rtVal;
        aluCtl.isBranch = 1'b1;
        aluCtl.branchNe = (execReq.opcode == opBne);
      end
      default: ;
    endcase
  end

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  issueValid,
  input  mipsExecPkg::execReqT  execReq,
  output logic                  resultValid,
  output mipsExecPkg::execRespT execResp
);
  import mipsExecPkg::*;

  aluCtlT      aluCtl;
  aluOutT      aluOut;
  logic [31:0] hiVal;
  logic [31:0] loVal;
  logic [31:0] respValue;
  logic        takeBranch;
  logic        noResult;

  aluControl i_aluControl (
    .execReq (execReq),
    .aluCtl  (aluCtl)
  );

  alu i_alu (
    .aluCtl (aluCtl),
    .aluOut (aluOut)
  );

  hiLoRegs i_hiLoRegs (
    .clk        (clk),
    .arstN      (arstN),
    .issueValid (issueValid),
    .aluCtl     (aluCtl),
    .newHi      (aluOut.hi),
    .newLo      (aluOut.lo),
    .hi         (hiVal),
    .lo         (loVal)
  );

  // branches and move-to instructions return zero
  assign noResult = aluCtl.isBranch | aluCtl.hiWrite | aluCtl.loWrite;

  always_comb begin
    if (aluCtl.readHi) begin
      respValue = hiVal;
    end else if (aluCtl.readLo) begin
      respValue = loVal;
    end else if (noResult) begin
      respValue = '0;
    end else begin
      respValue = aluOut.result; // zero for mult/div
    end
  end

  assign takeBranch = aluCtl.isBranch & (aluOut.eq ^ aluCtl.branchNe);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultValid <= 1'b0;
      execResp    <= '0;
    end else begin
      resultValid <= issueValid; // one cycle latency
      if (issueValid) begin
        execResp <= '{tag: execReq.tag, value: respValue, branchTaken: takeBranch};
      end
    end
  end

endmodule

/* source/hiLoRegs.sv */
`timescale 1ns/1ps

module hiLoRegs (
  input  logic                clk,
  input  logic                arstN,
  input  logic                issueValid,
  input  mipsExecPkg::aluCtlT aluCtl,
  input  logic [31:0]         newHi,
  input  logic [31:0]         newLo,
  output logic [31:0]         hi,
  output logic [31:0]         lo
);

  logic loadHi;
  logic loadLo;
  logic [31:0] nextHi;
  logic [31:0] nextLo;

  // mult/div writes both, mthi/mtlo writes one from operand A
  assign loadHi = issueValid & (aluCtl.hiLoWrite | aluCtl.hiWrite);
  assign loadLo = issueValid & (aluCtl.hiLoWrite | aluCtl.loWrite);
  assign nextHi = aluCtl.hiLoWrite ? newHi : aluCtl.operandA;
  assign nextLo = aluCtl.hiLoWrite ? newLo : aluCtl.operandA;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hi <= '0;
    end else if (loadHi) begin
      hi <= nextHi;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lo <= '0;
    end else if (loadLo) begin
      lo <= nextLo;
    end
  end

endmodule

/* source/mipsExecPkg.sv */
package mipsExecPkg;

  localparam logic [31:0] wordOnes   = 32'hffff_ffff;
  localparam logic [31:0] wordMinNeg = 32'h8000_0000; // most negative signed word

  // first eleven codes keep the classic alu numbering
  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluAnd   = 4'd2,
    aluOr    = 4'd3,
    aluSlt   = 4'd4,
    aluDiv   = 4'd5,
    aluMult  = 4'd6,
    aluSll   = 4'd7,
    aluXor   = 4'd8,
    aluSra   = 4'd9,
    aluSrl   = 4'd10,
    aluLui   = 4'd11,
    aluPassA = 4'd12 // operand A straight through
  } aluOpE;

  typedef enum logic [5:0] {
    opSpecial = 6'h00,
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddiu   = 6'h09,
    opSlti    = 6'h0a,
    opSltiu   = 6'h0b,
    opAndi    = 6'h0c,
    opOri     = 6'h0d,
    opXori    = 6'h0e,
    opLui     = 6'h0f
  } opcodeE;

  typedef enum logic [5:0] {
    fnSll   = 6'h00,
    fnSrl   = 6'h02,
    fnSra   = 6'h03,
    fnSllv  = 6'h04,
    fnSrlv  = 6'h06,
    fnSrav  = 6'h07,
    fnMfhi  = 6'h10,
    fnMthi  = 6'h11,
    fnMflo  = 6'h12,
    fnMtlo  = 6'h13,
    fnMult  = 6'h18,
    fnMultu = 6'h19,
    fnDiv   = 6'h1a,
    fnDivu  = 6'h1b,
    fnAdd   = 6'h20,
    fnAddu  = 6'h21,
    fnSub   = 6'h22,
    fnSubu  = 6'h23,
    fnAnd   = 6'h24,
    fnOr    = 6'h25,
    fnXor   = 6'h26,
    fnSlt   = 6'h2a,
    fnSltu  = 6'h2b
  } functE;

  typedef struct packed {
    opcodeE      opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [15:0] tag; // echoed back with the result
  } execReqT;

  typedef struct packed {
    aluOpE       op;
    logic        unsign;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic        hiLoWrite; // mult/div result into hi and lo
    logic        hiWrite;
    logic        loWrite;
    logic        readHi;
    logic        readLo;
    logic        isBranch;
    logic        branchNe;
  } aluCtlT;

  typedef struct packed {
    logic [31:0] result;
    logic [31:0] hi;
    logic [31:0] lo;
    logic        eq;
    logic        lt;
  } aluOutT;

  typedef struct packed {
    logic [15:0] tag;
    logic [31:0] value;
    logic        branchTaken;
  } execRespT;

endpackage

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    arstN = 1'b1;
    #1 arstN = 1'b0; // real falling edge for the async reset
    repeat (10) @(posedge clk);
    #5 arstN = 1'b1;
  end

endmodule

/* verification/executeChecker.sv */
`timescale 1ns/1ps

module executeChecker (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  issueValid,
  input  mipsExecPkg::execRespT expResp,
  input  logic                  resultValid,
  input  mipsExecPkg::execRespT execResp,
  input  string                 testName,
  output int                    errorCount,
  output int                    checkCount,
  output int                    pendingCount
);
  import mipsExecPkg::*;

  execRespT expQ[$];
  execRespT want;
  int       errors = 0;
  int       checks = 0;
  int       pending = 0;

  assign errorCount   = errors;
  assign checkCount   = checks;
  assign pendingCount = pending;

  task automatic compareField(input string field, input logic [31:0] expVal,
                              input logic [31:0] actVal);
    if (expVal !== actVal) begin
      errors++;
      $display("mismatch in %s: %s of tag %h expected %h, actual %h",
               testName, field, want.tag, expVal, actVal);
    end
  endtask

  // DUT outputs and driven inputs are both settled at the falling edge
  always @(negedge clk) begin
    if (!arstN) begin
      if (resultValid !== 1'b0) begin
        errors++;
        $display("resultValid is high while reset is asserted");
      end
    end else begin
      if (resultValid === 1'b1) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("result strobe for tag %h with no instruction outstanding", execResp.tag);
        end else begin
          if (expQ.size() > 1) begin
            errors++;
            $display("result came late, %0d instructions outstanding", expQ.size());
          end
          want = expQ.pop_front();
          checks++;
          compareField("tag", {16'h0, want.tag}, {16'h0, execResp.tag});
          compareField("value", want.value, execResp.value);
          compareField("branchTaken", {31'b0, want.branchTaken}, {31'b0, execResp.branchTaken});
        end
      end
      if (issueValid === 1'b1) begin
        expQ.push_back(expResp); // answered at the next falling edge
      end
    end
    pending = expQ.size();
  end

endmodule

/* verification/executeUnitTb.sv */
`timescale 1ns/1ps

module executeUnitTb;
  import mipsExecPkg::*;

  logic        clk;
  logic        arstN;
  logic        issueValid;
  execReqT     execReq;
  logic        resultValid;
  execRespT    execResp;
  execRespT    expResp;
  string       testName;
  int          errorCount;
  int          checkCount;
  int          pendingCount;
  integer      seed;
  logic [15:0] nextTag;
  logic [31:0] modelHi;
  logic [31:0] modelLo;
  int          groupErrs;
  int          waitFailures;
  logic [11:0] instPool[$]; // {opcode, funct}

  clockGen i_clockGen (
    .clk   (clk),
    .arstN (arstN)
  );

  executeUnit i_executeUnit (
    .clk         (clk),
    .arstN       (arstN),
    .issueValid  (issueValid),
    .execReq     (execReq),
    .resultValid (resultValid),
    .execResp    (execResp)
  );

  executeChecker i_executeChecker (
    .clk          (clk),
    .arstN        (arstN),
    .issueValid   (issueValid),
    .expResp      (expResp),
    .resultValid  (resultValid),
    .execResp     (execResp),
    .testName     (testName),
    .errorCount   (errorCount),
    .checkCount   (checkCount),
    .pendingCount (pendingCount)
  );

  function automatic logic [31:0] randOperand();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] < 4'd6) begin
      case (r[5:4])
        2'd0:    return 32'h0;
        2'd1:    return 32'h1;
        2'd2:    return 32'hffff_ffff;
        default: return 32'h8000_0000;
      endcase
    end
    r = $random(seed);
    return r;
  endfunction

  // sign bits decide first, equal signs compare like unsigned words
  function automatic logic signedLess(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) begin
      return a[31];
    end
    return a < b;
  endfunction

  function automatic logic [31:0] shiftRightArith(input logic [31:0] a,
                                                  input logic [4:0] amount);
    logic [31:0] fill;
    fill = a[31] ? ~(32'hffff_ffff >> amount) : 32'h0; // vacated top bits
    return (a >> amount) | fill;
  endfunction

  task automatic modelDivide(input logic [31:0] a, input logic [31:0] b, input logic signedOp);
    logic [31:0] magA;
    logic [31:0] magB;
    logic [31:0] q;
    logic [31:0] r;
    magA = (signedOp && a[31]) ? -a : a;
    magB = (signedOp && b[31]) ? -b : b;
    if (b == 32'h0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (signedOp && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;
      r = 32'h0;
    end else begin
      q = magA / magB;
      r = magA % magB;
      if (signedOp && (a[31] ^ b[31])) q = -q;
      if (signedOp && a[31]) r = -r; // remainder takes the dividend's sign
    end
    modelHi = r;
    modelLo = q;
  endtask

  task automatic modelIssue(input execReqT req, output execRespT resp);
    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] immS;
    logic [31:0] immZ;
    logic [31:0] val;
    logic [63:0] prod;
    logic        taken;
    rs = req.rsVal;
    rt = req.rtVal;
    immS = {{16{req.imm[15]}}, req.imm};
    immZ = {16'h0, req.imm};
    val = 32'h0;
    taken = 1'b0;
    case (req.opcode)
      opSpecial: begin
        case (functE'(req.funct))
          fnAdd, fnAddu: val = rs + rt;
          fnSub, fnSubu: val = rs - rt;
          fnAnd:  val = rs & rt;
          fnOr:   val = rs | rt;
          fnXor:  val = rs ^ rt;
          fnSlt:  val = {31'b0, signedLess(rs, rt)};
          fnSltu: val = {31'b0, rs < rt};
          fnSll:  val = rt << req.shamt;
          fnSrl:  val = rt >> req.shamt;
          fnSra:  val = shiftRightArith(rt, req.shamt);
          fnSllv: val = rt << rs[4:0];
          fnSrlv: val = rt >> rs[4:0];
          fnSrav: val = shiftRightArith(rt, rs[4:0]);
          fnMult: begin
            prod = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt}; // low 64 bits of sign-extended product
            modelHi = prod[63:32];
            modelLo = prod[31:0];
          end
          fnMultu: begin
            prod = {32'h0, rs} * {32'h0, rt};
            modelHi = prod[63:32];
            modelLo = prod[31:0];
          end
          fnDiv:  modelDivide(rs, rt, 1'b1);
          fnDivu: modelDivide(rs, rt, 1'b0);
          fnMfhi: val = modelHi;
          fnMflo: val = modelLo;
          fnMthi: modelHi = rs;
          fnMtlo: modelLo = rs;
          default: ;
        endcase
      end
      opAddiu: val = rs + immS;
      opSlti:  val = {31'b0, signedLess(rs, immS)};
      opSltiu: val = {31'b0, rs < immS};
      opAndi:  val = rs & immZ;
      opOri:   val = rs | immZ;
      opXori:  val = rs ^ immZ;
      opLui:   val = {req.imm, 16'h0};
      opBeq:   taken = (rs == rt);
      opBne:   taken = (rs != rt);
      default: ;
    endcase
    resp = '{tag: req.tag, value: val, branchTaken: taken};
  endtask

  task automatic driveIssue(input logic [11:0] inst, input logic [31:0] rs,
                            input logic [31:0] rt);
    execReqT     req;
    execRespT    resp;
    logic [31:0] bits;
    bits = $random(seed);
    req.opcode = opcodeE'(inst[11:6]);
    req.funct = inst[5:0];
    req.shamt = bits[4:0];
    req.imm = bits[31:16];
    req.rsVal = rs;
    req.rtVal = rt;
    req.tag = nextTag;
    nextTag++;
    modelIssue(req, resp);
    execReq = req;
    expResp = resp;
    issueValid = 1'b1;
  endtask

  task automatic issueAt(input logic [11:0] inst, input logic [31:0] rs, input logic [31:0] rt);
    @(posedge clk);
    #2;
    driveIssue(inst, rs, rt);
  endtask

  // hi and lo read back on the two cycles after the op
  task automatic opThenReadBack(input logic [11:0] inst, input logic [31:0] a,
                                input logic [31:0] b);
    issueAt(inst, a, b);
    issueAt({opSpecial, fnMfhi}, 32'h0, 32'h0);
    issueAt({opSpecial, fnMflo}, 32'h0, 32'h0);
  endtask

  task automatic randomIssues(input int count);
    int          issued;
    int          pick;
    logic [31:0] coin;
    logic [31:0] rs;
    logic [31:0] rt;
    issued = 0;
    while (issued < count) begin
      @(posedge clk);
      #2;
      coin = $random(seed);
      if (coin % 32'd10 < 32'd7) begin // about 70 percent issue density
        pick = $unsigned($random(seed)) % instPool.size();
        rs = randOperand();
        rt = (coin[9:8] == 2'b00) ? rs : randOperand();
        driveIssue(instPool[pick], rs, rt);
        issued++;
      end else begin
        issueValid = 1'b0;
      end
    end
  endtask

  task automatic startGroup(input string name);
    testName = name;
    groupErrs = errorCount;
  endtask

  task automatic finishGroup();
    int waited;
    @(posedge clk);
    #2;
    issueValid = 1'b0;
    waited = 0;
    while (pendingCount != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (pendingCount != 0) begin
      waitFailures++;
      $display("timeout in %s: %0d results never came back", testName, pendingCount);
    end else if (errorCount == groupErrs) begin
      $display("test %s passed", testName);
    end else begin
      $display("test %s failed with %0d errors", testName, errorCount - groupErrs);
    end
  endtask

  initial begin
    int waited;
    seed = 32'h9ef1ccbe;
    nextTag = 16'h0;
    modelHi = 32'h0;
    modelLo = 32'h0;
    waitFailures = 0;
    issueValid = 1'b0;
    execReq = '0;
    expResp = '0;
    startGroup("reset");
    @(posedge clk);
    waited = 0;
    while (arstN !== 1'b1 && waited < 40) begin
      @(posedge clk);
      waited++;
    end
    if (arstN !== 1'b1) begin
      waitFailures++;
      $display("reset was never released");
    end
    issueAt({opSpecial, fnMfhi}, randOperand(), randOperand()); // hi and lo still zero
    issueAt({opSpecial, fnMflo}, randOperand(), randOperand());
    finishGroup();

    startGroup("arith_logic");
    instPool = '{{opSpecial, fnAdd}, {opSpecial, fnAddu}, {opSpecial, fnSub},
                 {opSpecial, fnSubu}, {opSpecial, fnAnd}, {opSpecial, fnOr},
                 {opSpecial, fnXor}, {opAddiu, 6'h00}, {opAndi, 6'h00},
                 {opOri, 6'h00}, {opXori, 6'h00}, {opLui, 6'h00}};
    randomIssues(200);
    finishGroup();

    startGroup("compare_shift");
    instPool = '{{opSpecial, fnSlt}, {opSpecial, fnSltu}, {opSlti, 6'h00},
                 {opSltiu, 6'h00}, {opSpecial, fnSll}, {opSpecial, fnSrl},
                 {opSpecial, fnSra}, {opSpecial, fnSllv}, {opSpecial, fnSrlv},
                 {opSpecial, fnSrav}};
    randomIssues(200);
    finishGroup();

    startGroup("mult_div");
    instPool = '{{opSpecial, fnMult}, {opSpecial, fnMultu}, {opSpecial, fnDiv},
                 {opSpecial, fnDivu}, {opSpecial, fnMfhi}, {opSpecial, fnMflo}};
    randomIssues(200);
    opThenReadBack({opSpecial, fnDiv}, 32'h8000_0000, 32'hffff_ffff);
    opThenReadBack({opSpecial, fnDiv}, 32'hffff_fff9, 32'h0000_0002);
    opThenReadBack({opSpecial, fnDiv}, 32'h1234_5678, 32'h0);
    opThenReadBack({opSpecial, fnDivu}, 32'hffff_ffff, 32'h0);
    opThenReadBack({opSpecial, fnMult}, 32'h8000_0000, 32'h8000_0000);
    finishGroup();

    startGroup("moves");
    instPool = '{{opSpecial, fnMthi}, {opSpecial, fnMtlo}, {opSpecial, fnMfhi},
                 {opSpecial, fnMflo}, {opSpecial, fnMult}, {opSpecial, fnMultu}};
    randomIssues(200);
    opThenReadBack({opSpecial, fnMthi}, 32'hdead_beef, 32'h0);
    opThenReadBack({opSpecial, fnMtlo}, 32'h0bad_f00d, 32'h0);
    opThenReadBack({opSpecial, fnMultu}, 32'hffff_ffff, 32'hffff_ffff);
    finishGroup();

    startGroup("branches");
    instPool = '{{opBeq, 6'h00}, {opBne, 6'h00}};
    randomIssues(150);
    finishGroup();

    $display("%0d results checked, %0d errors, %0d timeouts", checkCount, errorCount,
             waitFailures);
    if (errorCount == 0 && waitFailures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
source/mipsExecPkg.sv
source/aluControl.sv
source/alu.sv
source/hiLoRegs.sv
source/executeUnit.sv
verification/clockGen.sv
verification/executeChecker.sv
verification/executeUnitTb.sv
